//--- logic/xcvr_reset_pkg.sv
package xcvr_reset_pkg;

	// system clock in MHz, scales the microsecond timers
	localparam int CLK_MHZ = 2;  // simulation value, small counters

	// rx digital reset hold after cdr lock, 4 us
	localparam int T_LTD_CYCLES = CLK_MHZ * 4;

	localparam int DIG_HOLD_CYCLES  = 3;  // user tx-only / rx-only pulse stretch
	localparam int ANA_SDONE_CYCLES = 2;  // done delay of tx digital and rx analog stages

	// status input conditioning
	localparam int SYNC_STAGES        = 2;  // synchronizer depth
	localparam int LOCK_FILTER_CYCLES = 4;  // stable cycles before a lock is believed

	// worst case from the last status event to a ready flag
	localparam int MAX_SEQ_CYCLES = SYNC_STAGES + LOCK_FILTER_CYCLES + T_LTD_CYCLES + 8;

	// reset stage FSM codes
	localparam logic [1:0] STG_HOLD = 2'd0;  // reset asserted
	localparam logic [1:0] STG_WAIT = 2'd1;  // reset released, timing rdone
	localparam logic [1:0] STG_DONE = 2'd2;  // sequence done, sticky

endpackage

//--- logic/status_sync.sv
`timescale 1ns/1ps

module status_sync
	import xcvr_reset_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic pll_is_locked,       // async from tx pll
	input  logic rx_oc_busy,          // async, offset cancellation running
	input  logic rx_is_lockedtodata,  // async from rx cdr
	output logic pll_locked_s,
	output logic oc_busy_s,
	output logic cdr_locked_s
);

	// bit 0 pll lock, bit 1 cdr lock, bit 2 oc busy
	logic [2:0] async_in;
	logic [2:0] sync_q [SYNC_STAGES];  // last entry is the clean copy
	logic [2:0] sync_out;
	int         lock_cnt [2];          // saturating stable count per lock path
	logic [1:0] lock_q;                // filtered lock, one bit per path

	assign async_in = {rx_oc_busy, rx_is_lockedtodata, pll_is_locked};
	assign sync_out = sync_q[SYNC_STAGES-1];

	// plain flop chain on all three inputs
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++)
				sync_q[i] <= 3'b100;  // busy until oc is seen idle
		end else begin
			sync_q[0] <= async_in;
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_q[i] <= sync_q[i-1];
		end
	end

	// glitch filter, both lock paths share this loop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++)
				lock_cnt[i] <= 0;
			lock_q <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!sync_out[i]) begin
					lock_cnt[i] <= 0;     // any low cycle restarts the filter
					lock_q[i]   <= 1'b0;
				end else if (lock_cnt[i] >= LOCK_FILTER_CYCLES - 1) begin
					lock_q[i] <= 1'b1;    // stable long enough
				end else begin
					lock_cnt[i] <= lock_cnt[i] + 1;
				end
			end
		end
	end

	// loss of lock passes straight through, no extra flop
	assign pll_locked_s = lock_q[0] & sync_out[0];
	assign cdr_locked_s = lock_q[1] & sync_out[1];
	assign oc_busy_s    = sync_out[2];  // level only, no filter

	// a filtered lock must be backed by the synchronized input one cycle earlier
	a_pll_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(pll_locked_s) |-> $past(sync_out[0]));
	a_cdr_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cdr_locked_s) |-> $past(sync_out[1]));

endmodule

//--- logic/reset_stage.sv
`timescale 1ns/1ps

// one step of a reset sequence
// reset is held while start is high, then released by a cycle count
// or by the rdone level; sdone follows once rdone has been stable
module reset_stage
	import xcvr_reset_pkg::*;
#(
	parameter int hold_cycles        = 3,  // count mode, cycles after start falls
	parameter bit hold_til_rdone     = 0,  // 1 = release on rdone, 0 = release on count
	parameter int sdone_delay_cycles = 1   // consecutive rdone cycles before sdone
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,  // level, restarts the stage from any state
	input  logic rdone,  // downstream ready, a level
	output logic reset,
	output logic sdone   // sticky until the next start
);

	logic [1:0] state;
	int         cnt;       // hold count in STG_HOLD, sdone delay in STG_WAIT
	logic       hold_end;  // leave STG_HOLD at this edge

	// release rule of the hold state
	assign hold_end = hold_til_rdone ? rdone : (cnt <= 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= STG_HOLD;
			cnt   <= hold_cycles;
		end else if (start) begin
			state <= STG_HOLD;     // restart, whatever the state
			cnt   <= hold_cycles;  // count begins once start drops
		end else begin
			case (state)
				STG_HOLD: begin
					if (hold_end) begin
						state <= STG_WAIT;
						cnt   <= sdone_delay_cycles;  // arm the done delay
					end else if (cnt > 0) begin
						cnt <= cnt - 1;
					end
				end
				STG_WAIT: begin
					if (!rdone) begin
						cnt <= sdone_delay_cycles;  // rdone dropped, start over
					end else if (cnt <= 1) begin
						state <= STG_DONE;
					end else begin
						cnt <= cnt - 1;
					end
				end
				STG_DONE: begin
					state <= STG_DONE;  // only start leaves here
				end
				default: begin
					state <= STG_HOLD;  // unused code, fall back to reset
					cnt   <= hold_cycles;
				end
			endcase
		end
	end

	// start forces reset in the same cycle, before the FSM catches up
	assign reset = start | (state == STG_HOLD);
	assign sdone = !start & (state == STG_DONE);

	// done and reset are exclusive
	a_sdone_no_reset: assert property (@(posedge clk) disable iff (!rst_n)
		sdone |-> !reset);

	a_start_reset: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> reset);

endmodule

//--- logic/ch_reset_ctrl.sv
`timescale 1ns/1ps

// channel reset order: tx pcs after tx pll lock, then rx pma once
// offset cancellation is idle, then rx pcs after cdr lock and settling
module ch_reset_ctrl
	import xcvr_reset_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic reset_all,         // restarts the whole sequence
	input  logic reset_tx_digital,  // user tx pcs only
	input  logic reset_rx_digital,  // user rx pcs only
	input  logic pll_locked_s,
	input  logic oc_busy_s,
	input  logic cdr_locked_s,
	output logic tx_digitalreset,   // tx pcs
	output logic rx_analogreset,    // rx pma
	output logic rx_digitalreset,   // rx pcs
	output logic tx_ready,
	output logic rx_ready
);

	logic tx_seq_rst;    // tx pcs reset from the sequence
	logic tx_seq_done;
	logic rx_ana_done;
	logic rx_seq_rst;    // rx pcs reset from the sequence
	logic rx_seq_done;
	logic tx_only_rst;   // stretched user pulse
	logic rx_only_rst;
	logic rx_ana_rdone;
	logic rx_dig_rdone;
	logic tx_only_start;
	logic rx_only_start;

	assign rx_ana_rdone  = !oc_busy_s & tx_seq_done;   // oc idle and tx side up
	assign rx_dig_rdone  = rx_ana_done & cdr_locked_s;
	assign tx_only_start = reset_all | reset_tx_digital;
	assign rx_only_start = reset_all | reset_rx_digital;

	// tx pcs waits for the pll
	reset_stage #(
		.hold_til_rdone     (1),
		.sdone_delay_cycles (ANA_SDONE_CYCLES)
	) tx_dig_seq (
		.clk   (clk),
		.rst_n (rst_n),
		.start (reset_all),
		.rdone (pll_locked_s),
		.reset (tx_seq_rst),
		.sdone (tx_seq_done)
	);

	reset_stage #(
		.hold_til_rdone     (1),
		.sdone_delay_cycles (ANA_SDONE_CYCLES)
	) rx_ana_seq (
		.clk   (clk),
		.rst_n (rst_n),
		.start (reset_all),
		.rdone (rx_ana_rdone),
		.reset (rx_analogreset),
		.sdone (rx_ana_done)
	);

	// rx pcs held for the lock-to-data settling time
	reset_stage #(
		.hold_til_rdone     (1),
		.sdone_delay_cycles (T_LTD_CYCLES)
	) rx_dig_seq (
		.clk   (clk),
		.rst_n (rst_n),
		.start (reset_all),
		.rdone (rx_dig_rdone),
		.reset (rx_seq_rst),
		.sdone (rx_seq_done)
	);

	// user pulses, count mode, ready follows the sequence done
	reset_stage #(
		.hold_cycles (DIG_HOLD_CYCLES)
	) tx_dig_only (
		.clk   (clk),
		.rst_n (rst_n),
		.start (tx_only_start),
		.rdone (tx_seq_done),
		.reset (tx_only_rst),
		.sdone (tx_ready)
	);

	reset_stage #(
		.hold_cycles (DIG_HOLD_CYCLES)
	) rx_dig_only (
		.clk   (clk),
		.rst_n (rst_n),
		.start (rx_only_start),
		.rdone (rx_seq_done),
		.reset (rx_only_rst),
		.sdone (rx_ready)
	);

	assign tx_digitalreset = tx_seq_rst | tx_only_rst;
	assign rx_digitalreset = rx_seq_rst | rx_only_rst;

	// rx pma is never out of reset ahead of the tx sequence
	a_rx_ana_order: assert property (@(posedge clk) disable iff (!rst_n)
		!rx_analogreset |-> !tx_seq_rst);

	// and rx pcs sequence never leads rx pma
	a_rx_dig_order: assert property (@(posedge clk) disable iff (!rst_n)
		!rx_seq_rst |-> !rx_analogreset);

endmodule

//--- logic/xcvr_reset_top.sv
`timescale 1ns/1ps

// one channel: status conditioning in front of the reset sequencer
module xcvr_reset_top (
	input  logic clk,
	input  logic rst_n,
	input  logic reset_all,
	input  logic reset_tx_digital,
	input  logic reset_rx_digital,
	input  logic pll_is_locked,       // async status from the transceiver
	input  logic rx_oc_busy,
	input  logic rx_is_lockedtodata,
	output logic tx_digitalreset,
	output logic rx_analogreset,
	output logic rx_digitalreset,
	output logic tx_ready,
	output logic rx_ready
);

	logic pll_locked_s;  // clk domain, filtered
	logic oc_busy_s;
	logic cdr_locked_s;

	status_sync sync0 (
		.clk                (clk),
		.rst_n              (rst_n),
		.pll_is_locked      (pll_is_locked),
		.rx_oc_busy         (rx_oc_busy),
		.rx_is_lockedtodata (rx_is_lockedtodata),
		.pll_locked_s       (pll_locked_s),
		.oc_busy_s          (oc_busy_s),
		.cdr_locked_s       (cdr_locked_s)
	);

	ch_reset_ctrl ctrl0 (
		.clk              (clk),
		.rst_n            (rst_n),
		.reset_all        (reset_all),
		.reset_tx_digital (reset_tx_digital),
		.reset_rx_digital (reset_rx_digital),
		.pll_locked_s     (pll_locked_s),
		.oc_busy_s        (oc_busy_s),
		.cdr_locked_s     (cdr_locked_s),
		.tx_digitalreset  (tx_digitalreset),
		.rx_analogreset   (rx_analogreset),
		.rx_digitalreset  (rx_digitalreset),
		.tx_ready         (tx_ready),
		.rx_ready         (rx_ready)
	);

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

// free running clock and a power-on reset for the testbench
module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int RST_CYCLES = 8;  // rst_n low this many clock periods

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;  // release on an edge, like a synchronized board reset
	end

endmodule

//--- tb/tb_xcvr_reset.sv
`timescale 1ns/1ps

module tb_xcvr_reset
	import xcvr_reset_pkg::*;
();

	localparam int NUM_ROWS    = 6;
	localparam int ACT_NONE    = 0;
	localparam int ACT_ALL     = 1;                // reset_all pulse
	localparam int ACT_TX      = 2;                // reset_tx_digital pulse
	localparam int ACT_RX      = 3;                // reset_rx_digital pulse
	localparam int PAD_BITS    = 2;                // random padding per delay, 0..3 cycles
	localparam int IDLE_CYCLES = SYNC_STAGES + 4;  // status drop plus reset_all pulse

	logic clk;
	logic rst_n;
	logic reset_all;
	logic reset_tx_digital;
	logic reset_rx_digital;
	logic pll_is_locked;
	logic rx_oc_busy;
	logic rx_is_lockedtodata;
	logic tx_digitalreset;
	logic rx_analogreset;
	logic rx_digitalreset;
	logic tx_ready;
	logic rx_ready;

	// pll delay, oc idle delay, cdr delay, glitch length, action, tx_ready drops, rx_ready drops
	int stim [NUM_ROWS][7] = '{
		'{10,  5, 20, 0, ACT_NONE, 0, 0},  // oc idle long before tx is up
		'{ 6, 30, 12, 3, ACT_ALL,  1, 1},  // oc is the last event
		'{15,  2, 40, 2, ACT_TX,   1, 0},
		'{ 6,  8,  8, 3, ACT_RX,   0, 1},
		'{20, 25,  5, 1, ACT_ALL,  1, 1},  // cdr locks before rx pma is out
		'{ 8,  0, 50, 3, ACT_TX,   1, 0}   // cdr glitch lands after rx pma is done
	};

	logic [31:0] lfsr = 32'hbfb4;
	int          err_count;   // wrong values
	int          fail_count;  // missed events
	int          pll_d;       // delays of the current row, padded
	int          oc_d;
	int          cdr_d;
	int          glitch;

	tb_clk_gen clk_gen0 (
		.clk   (clk),
		.rst_n (rst_n)
	);

	xcvr_reset_top dut0 (
		.clk                (clk),
		.rst_n              (rst_n),
		.reset_all          (reset_all),
		.reset_tx_digital   (reset_tx_digital),
		.reset_rx_digital   (reset_rx_digital),
		.pll_is_locked      (pll_is_locked),
		.rx_oc_busy         (rx_oc_busy),
		.rx_is_lockedtodata (rx_is_lockedtodata),
		.tx_digitalreset    (tx_digitalreset),
		.rx_analogreset     (rx_analogreset),
		.rx_digitalreset    (rx_digitalreset),
		.tx_ready           (tx_ready),
		.rx_ready           (rx_ready)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);  // one step per bit
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic int max3(input int a, input int b, input int c);
		int m;
		m = a;
		if (b > m)
			m = b;
		if (c > m)
			m = c;
		return m;
	endfunction

	task automatic report_bit(input string name, input logic exp, input logic got);
		$display("Error at %0t ns: %s expected %0b, got %0b", $time, name, exp, got);
		err_count++;
	endtask

	task automatic report_fail(input string what);
		$display("Failure at %0t ns: %s", $time, what);
		fail_count++;
	endtask

	// a lock glitch ends two cycles before the real lock, so the filter restarts
	task automatic drive_status(input int cyc);
		logic pll_v;
		logic cdr_v;
		pll_v = (cyc >= pll_d) ||
			(glitch > 0 && cyc >= pll_d - glitch - 2 && cyc < pll_d - 2);
		cdr_v = (cyc >= cdr_d) ||
			(glitch > 0 && cyc >= cdr_d - glitch - 2 && cyc < cdr_d - 2);
		pll_is_locked      <= pll_v;
		rx_oc_busy         <= (cyc < oc_d);
		rx_is_lockedtodata <= cdr_v;
	endtask

	// every reset asserted, nothing ready
	task automatic expect_idle();
		if (tx_digitalreset !== 1'b1)
			report_bit("tx_digitalreset", 1'b1, tx_digitalreset);
		if (rx_analogreset !== 1'b1)
			report_bit("rx_analogreset", 1'b1, rx_analogreset);
		if (rx_digitalreset !== 1'b1)
			report_bit("rx_digitalreset", 1'b1, rx_digitalreset);
		if (tx_ready !== 1'b0)
			report_bit("tx_ready", 1'b0, tx_ready);
		if (rx_ready !== 1'b0)
			report_bit("rx_ready", 1'b0, rx_ready);
	endtask

	// user request once both sides are ready, then wait for ready to return
	task automatic apply_action(input int r);
		int   act;
		logic tx_drop;
		logic rx_drop;
		int   hold_tx;
		int   hold_rx;
		int   n;
		act     = stim[r][4];
		tx_drop = (stim[r][5] != 0);
		rx_drop = (stim[r][6] != 0);
		hold_tx = 0;
		hold_rx = 0;
		n       = 0;
		@(posedge clk);
		reset_all        <= (act == ACT_ALL);
		reset_tx_digital <= (act == ACT_TX);
		reset_rx_digital <= (act == ACT_RX);
		@(negedge clk);
		if (tx_digitalreset !== tx_drop)
			report_bit("tx_digitalreset", tx_drop, tx_digitalreset);
		if (tx_ready !== !tx_drop)
			report_bit("tx_ready", !tx_drop, tx_ready);
		if (rx_digitalreset !== rx_drop)
			report_bit("rx_digitalreset", rx_drop, rx_digitalreset);
		if (rx_ready !== !rx_drop)
			report_bit("rx_ready", !rx_drop, rx_ready);
		if (rx_analogreset !== (act == ACT_ALL))
			report_bit("rx_analogreset", act == ACT_ALL, rx_analogreset);
		while (n < MAX_SEQ_CYCLES + 2 && !(tx_ready === 1'b1 && rx_ready === 1'b1)) begin
			@(posedge clk);
			reset_all        <= 1'b0;  // single cycle request
			reset_tx_digital <= 1'b0;
			reset_rx_digital <= 1'b0;
			@(negedge clk);
			n++;
			if (tx_digitalreset === 1'b1)
				hold_tx++;
			if (rx_digitalreset === 1'b1)
				hold_rx++;
			// the untouched side keeps running
			if (!tx_drop && tx_ready !== 1'b1)
				report_bit("tx_ready", 1'b1, tx_ready);
			if (!tx_drop && tx_digitalreset !== 1'b0)
				report_bit("tx_digitalreset", 1'b0, tx_digitalreset);
			if (!rx_drop && rx_ready !== 1'b1)
				report_bit("rx_ready", 1'b1, rx_ready);
			if (!rx_drop && rx_digitalreset !== 1'b0)
				report_bit("rx_digitalreset", 1'b0, rx_digitalreset);
			if (act != ACT_ALL && rx_analogreset !== 1'b0)
				report_bit("rx_analogreset", 1'b0, rx_analogreset);
		end
		if (tx_drop && hold_tx < DIG_HOLD_CYCLES)
			report_fail($sformatf("tx_digitalreset held only %0d cycles", hold_tx));
		if (rx_drop && hold_rx < DIG_HOLD_CYCLES)
			report_fail($sformatf("rx_digitalreset held only %0d cycles", hold_rx));
		if (tx_ready !== 1'b1)
			report_fail("tx_ready never rose after the user request");
		if (rx_ready !== 1'b1)
			report_fail("rx_ready never rose after the user request");
	endtask

	initial begin
		int tx_fall;   // row cycle of each release, -1 while still held
		int ana_fall;
		int dig_fall;
		int last;
		int pad;
		int cyc;
		reset_all          = 1'b0;
		reset_tx_digital   = 1'b0;
		reset_rx_digital   = 1'b0;
		pll_is_locked      = 1'b0;
		rx_oc_busy         = 1'b1;  // offset cancellation runs from power-up
		rx_is_lockedtodata = 1'b0;
		err_count          = 0;
		fail_count         = 0;
		@(posedge rst_n);
		@(negedge clk);
		expect_idle();  // no lock yet
		for (int r = 0; r < NUM_ROWS; r++) begin
			take_bits(PAD_BITS, pad);
			pll_d = stim[r][0] + pad;
			take_bits(PAD_BITS, pad);
			oc_d = stim[r][1] + pad;
			take_bits(PAD_BITS, pad);
			cdr_d  = stim[r][2] + pad;
			glitch = stim[r][3];
			$display("row %0d: pll %0d oc %0d cdr %0d glitch %0d action %0d",
				r, pll_d, oc_d, cdr_d, glitch, stim[r][4]);
			// drop all status, let it pass the synchronizer, restart
			@(posedge clk);
			pll_is_locked      <= 1'b0;
			rx_oc_busy         <= 1'b1;
			rx_is_lockedtodata <= 1'b0;
			repeat (SYNC_STAGES + 2) @(posedge clk);
			reset_all <= 1'b1;
			@(negedge clk);
			expect_idle();
			tx_fall  = -1;
			ana_fall = -1;
			dig_fall = -1;
			last     = max3(pll_d, oc_d, cdr_d);
			cyc      = 0;
			while (cyc <= last + MAX_SEQ_CYCLES + 2 &&
					!(tx_ready === 1'b1 && rx_ready === 1'b1)) begin
				@(posedge clk);
				reset_all <= 1'b0;
				drive_status(cyc);
				@(negedge clk);
				if (tx_fall < 0 && tx_digitalreset === 1'b0)
					tx_fall = cyc;
				if (ana_fall < 0 && rx_analogreset === 1'b0)
					ana_fall = cyc;
				if (dig_fall < 0 && rx_digitalreset === 1'b0)
					dig_fall = cyc;
				// tx pcs waits for a pll lock that has passed the filter
				if (cyc < pll_d + SYNC_STAGES + LOCK_FILTER_CYCLES && tx_digitalreset !== 1'b1)
					report_bit("tx_digitalreset", 1'b1, tx_digitalreset);
				if ((tx_fall < 0 || cyc < tx_fall + ANA_SDONE_CYCLES) && tx_ready !== 1'b0)
					report_bit("tx_ready", 1'b0, tx_ready);
				// rx pma needs tx done and oc idle
				if ((tx_fall < 0 || cyc < tx_fall + ANA_SDONE_CYCLES ||
						cyc < oc_d + SYNC_STAGES) && rx_analogreset !== 1'b1)
					report_bit("rx_analogreset", 1'b1, rx_analogreset);
				// rx pcs needs rx pma done and a filtered cdr lock
				if ((ana_fall < 0 || cyc < ana_fall + ANA_SDONE_CYCLES ||
						cyc < cdr_d + SYNC_STAGES + LOCK_FILTER_CYCLES) &&
						rx_digitalreset !== 1'b1)
					report_bit("rx_digitalreset", 1'b1, rx_digitalreset);
				// lock-to-data settling before rx_ready
				if ((dig_fall < 0 || cyc < dig_fall + T_LTD_CYCLES) && rx_ready !== 1'b0)
					report_bit("rx_ready", 1'b0, rx_ready);
				cyc++;
			end
			if (tx_fall < 0)
				report_fail("tx_digitalreset never fell after the pll lock");
			if (ana_fall < 0)
				report_fail("rx_analogreset never fell after oc went idle");
			if (dig_fall < 0)
				report_fail("rx_digitalreset never fell after the cdr lock");
			if (tx_ready !== 1'b1)
				report_fail("tx_ready never rose");
			if (rx_ready !== 1'b1)
				report_fail("rx_ready never rose");
			apply_action(r);
		end
		$display("summary: %0d value errors, %0d other failures", err_count, fail_count);
		if (err_count == 0 && fail_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// per row: longest delay and padding, idle phase, bring-up and the user request
	initial begin
		int max_dly;
		int limit;
		max_dly = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			max_dly = max3(max_dly, max3(stim[r][0], stim[r][1], stim[r][2]), 0);
		limit = NUM_ROWS * (max_dly + (1 << PAD_BITS) + IDLE_CYCLES + 3 * MAX_SEQ_CYCLES) + 16;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- project.f
logic/xcvr_reset_pkg.sv
logic/status_sync.sv
logic/reset_stage.sv
logic/ch_reset_ctrl.sv
logic/xcvr_reset_top.sv
tb/tb_clk_gen.sv
tb/tb_xcvr_reset.sv

//--- Makefile
TOP := tb_xcvr_reset

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
